/* sim.f */
design/adc_pkg.sv
design/adc_regs.sv
design/adc_serial.sv
design/adc_rate.sv
design/adc_control_top.sv
verification/tb_adc_control.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_adc_control
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := SIMULATION FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails on a nonzero exit or on the fail message in the log
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_adc_control.sv */
// ADC model sends one fixed word per channel round-robin; DIVIDE in this run stays at or below 3
`timescale 1ns/1ps

module tb_adc_control import adc_pkg::*; ();

  localparam int MAX_DIVIDE      = 3;
  // Longest frame plus gap in clk cycles
  localparam int FRAME_CYCLES    = (FRAME_BITS + GAP_BITS) * 2 * (MAX_DIVIDE + 1);
  localparam int WATCHDOG_CYCLES = 40 * FRAME_CYCLES + 1000;
  localparam int POLL_LIMIT      = 100;
  localparam int RATE_PERIOD     = 5;
  localparam int SEQ_PERIOD      = 20;
  localparam int SEQ_STEPS       = 10;

  logic        clk;
  logic        reset;
  logic [15:0] addr;
  logic [31:0] data_in;
  logic        enable;
  logic        re;
  logic        wr;
  sample_t     data_out;
  logic        output_sample;
  logic [7:0]  channel_select;
  logic [31:0] sample_data;
  logic        sample_valid;
  logic        cs;
  logic        adc_sclk;
  logic        adc_din;
  logic        adc_dout;
  time_t       current_time;

  // ADC model and monitor state
  sample_t     adc_words [NUM_CHANNELS];
  int          word_idx;
  int          bit_idx;
  integer      seed;
  logic        time_run;
  logic        prev_sclk;
  logic        prev_cs;
  int          rises;
  int          last_rises;
  int          high_run;
  int          last_high;
  int          frames_done;
  sample_t     din_shift;
  int          din_bits;
  sample_t     prog_word;
  seq_t        win_seq;
  int          value_errors;
  int          other_errors;

  adc_control_top u_dut (
    .clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .enable(enable),
    .re(re), .wr(wr), .data_out(data_out), .output_sample(output_sample),
    .channel_select(channel_select), .sample_data(sample_data),
    .sample_valid(sample_valid), .cs(cs), .adc_sclk(adc_sclk), .adc_din(adc_din),
    .adc_dout(adc_dout), .current_time(current_time)
  );

  always #5 clk = ~clk;

  // Host timestamp, 1 in the first cycle after reset
  always @(posedge clk) begin
    time_run = !reset;
    #1;
    current_time = time_run ? current_time + 1 : '0;
  end

  // ----------------------------------------
  // ADC model and pin monitor
  // ----------------------------------------
  // Next data bit on every sclk rise, 16 rises per word
  always @(posedge adc_sclk) begin
    #1;
    adc_dout = adc_words[word_idx][FRAME_BITS-1-bit_idx];
    if (bit_idx == FRAME_BITS-1) begin
      bit_idx  = 0;
      word_idx = (word_idx + 1) % NUM_CHANNELS;
    end else begin
      bit_idx = bit_idx + 1;
    end
  end

  // Pins looked at mid cycle, away from the clk edge
  always @(negedge clk) begin
    if (prev_sclk === 1'b0 && adc_sclk === 1'b1 && cs === 1'b0) begin
      rises = rises + 1;
    end
    if (adc_sclk === 1'b1) begin
      high_run = high_run + 1;
    end else if (prev_sclk === 1'b1) begin
      last_high = high_run;
      high_run  = 0;
    end
    // Command bits seen by the ADC at each sclk fall
    if (prev_sclk === 1'b1 && adc_sclk === 1'b0 && cs === 1'b0) begin
      din_shift = {din_shift[FRAME_BITS-2:0], adc_din};
      din_bits  = din_bits + 1;
      if (din_bits == FRAME_BITS && din_shift != '0) begin
        prog_word = din_shift;
      end
    end
    if (prev_cs === 1'b0 && cs === 1'b1) begin
      frames_done = frames_done + 1;
      last_rises  = rises;
      rises       = 0;
      din_bits    = 0;
    end
    prev_sclk = adc_sclk;
    prev_cs   = cs;
  end

  // ----------------------------------------
  // Reference functions and compares
  // ----------------------------------------
  function automatic logic window_open(input time_t start_t, input time_t end_t, input time_t now);
    return (start_t != '0) && (start_t < now) && ((now < end_t) || (end_t == '0));
  endfunction

  function automatic time_t stream_value(input logic open, input seq_t seq, input sample_t smp);
    return open ? {seq, smp} : CLOSED_PATTERN;
  endfunction

  // Channel index rides in the top 3 bits
  function automatic sample_t expected_frame(input chan_t ch, input logic [12:0] data_bits);
    return {ch, data_bits};
  endfunction

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%04h expected 0x%04h", name, got, exp);
    end
  endtask

  task automatic check_stream(input string name, input time_t got, input time_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // ----------------------------------------
  // Bus and wait tasks
  // ----------------------------------------
  task automatic bus_write(input logic [7:0] code, input reg_off_t off, input logic [31:0] data);
    @(posedge clk);
    #1;
    addr    = {code, 4'h0, off};
    data_in = data;
    enable  = 1'b1;
    wr      = 1'b1;
    @(posedge clk);
    #1;
    enable = 1'b0;
    wr     = 1'b0;
  endtask

  // Read data is registered, taken one clock after re
  task automatic bus_read(input logic [7:0] code, input reg_off_t off, output sample_t val);
    @(posedge clk);
    #1;
    addr   = {code, 4'h0, off};
    enable = 1'b1;
    re     = 1'b1;
    @(posedge clk);
    #1;
    enable = 1'b0;
    re     = 1'b0;
    val    = data_out;
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  task automatic wait_frames(input int count);
    int target;
    int waited;
    target = frames_done + count;
    waited = 0;
    while (frames_done < target && waited < count * FRAME_CYCLES + 200) begin
      @(posedge clk);
      waited++;
    end
    if (frames_done < target) begin
      other_errors++;
      $display("ADC frames stopped, %0d of %0d completed", count - target + frames_done, count);
    end
  endtask

  task automatic wait_busy(input logic level);
    sample_t val;
    int      polls;
    polls = 0;
    do begin
      bus_read(8'd100, OFF_BUSY, val);
      polls++;
    end while (val[0] !== level && polls < POLL_LIMIT);
    if (val[0] !== level) begin
      other_errors++;
      $display("BUSY never read %0d while waiting for the program frame", level);
    end
  endtask

  // Stream request on channel 2, expected value from the window at the sampling edge
  task automatic stream_check(input string what, input time_t st, input time_t en);
    time_t now;
    time_t got;
    logic  vld;
    @(posedge clk);
    #1;
    output_sample  = 1'b1;
    channel_select = 8'd102;
    @(posedge clk);
    now = current_time;
    #1;
    output_sample = 1'b0;
    got = sample_data;
    vld = sample_valid;
    check_bit({what, " sample_valid"}, vld, 1'b1);
    check_stream({what, " sample_data"}, got,
                 stream_value(window_open(st, en, now), win_seq, adc_words[2]));
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    sample_t     rd;
    seq_t        seq_a;
    seq_t        seq_b;
    time_t       st;
    time_t       en;
    int          diff;
    logic [31:0] rnd;
    clk = 1'b0;
    reset = 1'b1;
    addr = '0;
    data_in = '0;
    enable = 1'b0;
    re = 1'b0;
    wr = 1'b0;
    output_sample = 1'b0;
    channel_select = '0;
    adc_dout = 1'b0;
    current_time = '0;
    word_idx = 0;
    bit_idx = 0;
    prev_sclk = 1'b0;
    prev_cs = 1'b1;
    rises = 0;
    last_rises = 0;
    high_run = 0;
    last_high = 0;
    frames_done = 0;
    din_shift = '0;
    din_bits = 0;
    prog_word = '0;
    value_errors = 0;
    other_errors = 0;
    seed = 32'hd846;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      rnd = $random(seed);
      adc_words[c] = expected_frame(chan_t'(c), rnd[12:0]);
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // ID and codes just outside the channel range
    bus_read(8'd100, OFF_ID, rd);
    check_sample("data_out ID", rd, ID_VALUE);
    bus_read(8'd99, OFF_ID, rd);
    check_sample("data_out code 99", rd, '0);
    bus_read(8'd108, OFF_ID, rd);
    check_sample("data_out code 108", rd, '0);

    // Command frame out on adc_din
    bus_write(8'd103, OFF_PROGRAM, {ADC_CMD_NEW_VALUE, 16'hA5C3});
    wait_busy(1'b1);
    wait_busy(1'b0);
    bus_read(8'd103, OFF_LAST, rd);
    check_sample("data_out LAST", rd, 16'hA5C3);
    check_sample("adc_din frame", prog_word, 16'hA5C3);

    // OVERFLOW still 0 here
    bus_read(8'd107, OFF_SEQUENCE, rd);
    check_sample("data_out SEQUENCE ch7", rd, '0);

    // Samples after two full rounds and one period
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      bus_write(8'(MIN_CHANNEL + c), OFF_OVERFLOW, 32'(RATE_PERIOD));
    end
    wait_frames(2 * NUM_CHANNELS + 1);
    wait_cycles(RATE_PERIOD);
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      bus_read(8'(MIN_CHANNEL + c), OFF_SAMPLE, rd);
      check_sample($sformatf("data_out SAMPLE ch%0d", c), rd, adc_words[c]);
    end

    // Sequence rate on channel 1
    bus_write(8'd101, OFF_OVERFLOW, 32'(SEQ_PERIOD));
    bus_read(8'd101, OFF_SEQUENCE, seq_a);
    wait_cycles(SEQ_STEPS * SEQ_PERIOD);
    bus_read(8'd101, OFF_SEQUENCE, seq_b);
    diff = int'(seq_t'(seq_b - seq_a));
    if (diff < SEQ_STEPS - 1 || diff > SEQ_STEPS + 1) begin
      other_errors++;
      $display("Channel 1 sequence moved by %0d over %0d periods", diff, SEQ_STEPS);
    end

    // Recording window on a frozen channel 2
    bus_write(8'd102, OFF_OVERFLOW, 32'd0);
    bus_read(8'd102, OFF_SEQUENCE, win_seq);
    stream_check("start 0", '0, '0);
    st = current_time + 100;
    en = current_time + 300;
    bus_write(8'd102, OFF_RECSTART, st);
    bus_write(8'd102, OFF_ENDTIME, en);
    stream_check("before start", st, en);
    wait_cycles(120);
    stream_check("inside window", st, en);
    wait_cycles(200);
    stream_check("after end", st, en);
    bus_write(8'd102, OFF_ENDTIME, 32'd0);
    stream_check("end 0", st, '0);

    // Bit clock shape at the slowest divide
    bus_write(8'd100, OFF_DIVIDE, 32'(MAX_DIVIDE));
    wait_frames(3);
    check_sample("adc_sclk high cycles", sample_t'(last_high), sample_t'(MAX_DIVIDE + 1));
    check_sample("adc_sclk rises per frame", sample_t'(last_rises), sample_t'(FRAME_BITS));

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* design/adc_control_top.sv */
// ADC sequencing controller top; single clock, no bus handshake, one external 8-channel ADC
`timescale 1ns/1ps

module adc_control_top import adc_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] addr,
  input  logic [31:0] data_in,
  input  logic        enable,
  input  logic        re,
  input  logic        wr,
  output sample_t     data_out,
  input  logic        output_sample,
  input  logic [7:0]  channel_select,
  output logic [31:0] sample_data,
  output logic        sample_valid,
  output logic        cs,
  output logic        adc_sclk,
  output logic        adc_din,
  input  logic        adc_dout,
  input  time_t       current_time
);

  // Register block to serial engine
  sample_t                    divide;
  sample_t                    cmd_word;
  logic                       cmd_pending;
  logic                       cmd_taken;
  logic                       busy;
  sample_t                    last_cmd;
  // Serial engine to rate block
  logic                       frame_valid;
  sample_t                    frame_word;
  // Rate block and configuration buses
  sample_t [NUM_CHANNELS-1:0] overflow_bus;
  sample_t [NUM_CHANNELS-1:0] sample_bus;
  seq_t [NUM_CHANNELS-1:0]    seq_bus;

  adc_regs u_regs (
    .clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .enable(enable),
    .re(re), .wr(wr), .output_sample(output_sample), .channel_select(channel_select),
    .current_time(current_time), .sample_bus(sample_bus), .seq_bus(seq_bus),
    .busy(busy), .last_cmd(last_cmd), .cmd_taken(cmd_taken), .data_out(data_out),
    .sample_data(sample_data), .sample_valid(sample_valid), .divide(divide),
    .overflow_bus(overflow_bus), .cmd_word(cmd_word), .cmd_pending(cmd_pending)
  );

  adc_serial u_serial (
    .clk(clk), .reset(reset), .divide(divide), .cmd_pending(cmd_pending),
    .cmd_word(cmd_word), .current_time(current_time), .adc_dout(adc_dout),
    .cs(cs), .adc_sclk(adc_sclk), .adc_din(adc_din), .busy(busy),
    .cmd_taken(cmd_taken), .last_cmd(last_cmd), .frame_valid(frame_valid),
    .frame_word(frame_word)
  );

  adc_rate u_rate (
    .clk(clk), .reset(reset), .frame_valid(frame_valid), .frame_word(frame_word),
    .overflow_bus(overflow_bus), .sample_bus(sample_bus), .seq_bus(seq_bus)
  );

endmodule

/* design/adc_rate.sv */
// Rate counters; OVERFLOW 0 holds a channel, a lowered OVERFLOW takes effect on the next clock
`timescale 1ns/1ps

module adc_rate import adc_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       frame_valid,
  input  sample_t                    frame_word,
  input  sample_t [NUM_CHANNELS-1:0] overflow_bus,
  output sample_t [NUM_CHANNELS-1:0] sample_bus,
  output seq_t [NUM_CHANNELS-1:0]    seq_bus
);

  sample_t staging [NUM_CHANNELS];
  chan_t   frame_chan;

  // ----------------------------------------
  // Staging slots
  // ----------------------------------------
  // Top bits of a frame name its channel
  assign frame_chan = frame_word[FRAME_BITS-1 -: $bits(chan_t)];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        staging[i] <= '0;
      end
    end else if (frame_valid) begin
      staging[frame_chan] <= frame_word;
    end
  end

  // ----------------------------------------
  // Per-channel rate counters
  // ----------------------------------------
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
    sample_t rate_cnt;
    sample_t sample_q;
    seq_t    seq_q;
    logic    tick;

    // Period elapsed, also catches a period lowered mid count
    assign tick = (overflow_bus[ch] != '0) && (rate_cnt >= overflow_bus[ch]);

    always_ff @(posedge clk) begin
      if (reset) begin
        rate_cnt <= 16'd1;
        sample_q <= '0;
        seq_q    <= '0;
      end else if (overflow_bus[ch] == '0) begin
        // Disabled channel waits at the start count
        rate_cnt <= 16'd1;
      end else if (tick) begin
        rate_cnt <= 16'd1;
        sample_q <= staging[ch];
        seq_q    <= seq_q + 1'b1;
      end else begin
        rate_cnt <= rate_cnt + 1'b1;
      end
    end

    assign sample_bus[ch] = sample_q;
    assign seq_bus[ch]    = seq_q;
  end

endmodule

/* design/adc_serial.sv */
// Serial frame engine; a DIVIDE change applies mid frame, commands wait for the idle state
`timescale 1ns/1ps

module adc_serial import adc_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  sample_t divide,
  input  logic    cmd_pending,
  input  sample_t cmd_word,
  input  time_t   current_time,
  input  logic    adc_dout,
  output logic    cs,
  output logic    adc_sclk,
  output logic    adc_din,
  output logic    busy,
  output logic    cmd_taken,
  output sample_t last_cmd,
  output logic    frame_valid,
  output sample_t frame_word
);

  serial_state_t                 state;
  sample_t                       half_cnt;
  logic                          second_half;
  logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
  sample_t                       shift_out;
  sample_t                       shift_in;
  sample_t                       cmd_hold;
  logic                          in_frame;
  logic                          half_end;
  logic                          bit_end;
  logic                          sclk_fall;

  // ----------------------------------------
  // Bit timing
  // ----------------------------------------
  // Half period is divide+1 clocks
  assign in_frame  = (state == ST_PROGRAM) || (state == ST_CONVERT);
  assign half_end  = half_cnt >= divide;
  assign bit_end   = half_end && second_half;
  assign sclk_fall = in_frame && half_end && !second_half;

  assign cs         = !in_frame;
  assign busy       = state == ST_PROGRAM;
  // MSB first, zero outside program frames
  assign adc_din    = shift_out[FRAME_BITS-1];
  // First clock of a program frame
  assign cmd_taken  = busy && (bit_cnt == '0) && !second_half && (half_cnt == '0);
  assign frame_word = shift_in;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      half_cnt    <= '0;
      second_half <= 1'b0;
      bit_cnt     <= '0;
      adc_sclk    <= 1'b0;
      shift_out   <= '0;
      last_cmd    <= '0;
      frame_valid <= 1'b0;
    end else begin
      // Pulse in the clock after the 16th sample
      frame_valid <= (state == ST_CONVERT) && sclk_fall && (bit_cnt == FRAME_BITS-1);
      if (state != ST_IDLE) begin
        if (half_end) begin
          half_cnt    <= '0;
          second_half <= !second_half;
        end else begin
          half_cnt <= half_cnt + 1'b1;
        end
      end
      case (state)
        ST_IDLE: begin
          half_cnt    <= '0;
          second_half <= 1'b0;
          bit_cnt     <= '0;
          // Commands before conversions
          if (cmd_pending) begin
            state     <= ST_PROGRAM;
            adc_sclk  <= 1'b1;
            shift_out <= cmd_word;
          end else if (current_time != '0) begin
            state     <= ST_CONVERT;
            adc_sclk  <= 1'b1;
            shift_out <= '0;
          end
        end
        ST_PROGRAM, ST_CONVERT: begin
          if (sclk_fall) begin
            adc_sclk <= 1'b0;
          end
          if (bit_end) begin
            shift_out <= {shift_out[FRAME_BITS-2:0], 1'b0};
            if (bit_cnt == FRAME_BITS-1) begin
              state   <= ST_COPY;
              bit_cnt <= '0;
              if (busy) begin
                last_cmd <= cmd_hold;
              end
            end else begin
              bit_cnt  <= bit_cnt + 1'b1;
              adc_sclk <= 1'b1;
            end
          end
        end
        // Gap with cs high and sclk low
        ST_COPY: begin
          if (bit_end) begin
            if (bit_cnt == GAP_BITS-1) begin
              state <= ST_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command copy for LAST and the capture shifter
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && cmd_pending) begin
      cmd_hold <= cmd_word;
    end
    if ((state == ST_CONVERT) && sclk_fall) begin
      shift_in <= {shift_in[FRAME_BITS-2:0], adc_dout};
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  assert property (@(posedge clk) disable iff (reset)
    (state == ST_IDLE || state == ST_COPY) |-> (cs && !adc_sclk));
  assert property (@(posedge clk) disable iff (reset)
    $rose(busy) |-> (cmd_taken && $past(cmd_pending)));
  // Capture pulse lands in the low half of the last bit, never in a program frame
  assert property (@(posedge clk) disable iff (reset)
    frame_valid |-> (!cs && !adc_sclk && !busy));

endmodule

/* design/adc_regs.sv */
// Bus registers; a PROGRAM write replaces any pending command, reads return data one clock later
`timescale 1ns/1ps

module adc_regs import adc_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [15:0]                  addr,
  input  logic [31:0]                  data_in,
  input  logic                         enable,
  input  logic                         re,
  input  logic                         wr,
  input  logic                         output_sample,
  input  logic [7:0]                   channel_select,
  input  time_t                        current_time,
  input  sample_t [NUM_CHANNELS-1:0]   sample_bus,
  input  seq_t [NUM_CHANNELS-1:0]      seq_bus,
  input  logic                         busy,
  input  sample_t                      last_cmd,
  input  logic                         cmd_taken,
  output sample_t                      data_out,
  output logic [31:0]                  sample_data,
  output logic                         sample_valid,
  output sample_t                      divide,
  output sample_t [NUM_CHANNELS-1:0]   overflow_bus,
  output sample_t                      cmd_word,
  output logic                         cmd_pending
);

  logic     bus_hit;
  chan_t    bus_chan;
  reg_off_t bus_off;
  logic     bus_wr;
  logic     cmd_write;
  time_t    end_time [NUM_CHANNELS];
  time_t    start_time [NUM_CHANNELS];
  logic     sel_hit;
  chan_t    sel_chan;
  time_t    sel_start;
  time_t    sel_end;
  logic     window_open;

  // ----------------------------------------
  // Bus decode
  // ----------------------------------------
  // Channel field in addr 15:8, offset in 3:0
  assign bus_hit  = enable && (addr[15:8] >= 8'(MIN_CHANNEL)) && (addr[15:8] <= 8'(MAX_CHANNEL));
  assign bus_chan = chan_t'(addr[15:8] - 8'(MIN_CHANNEL));
  assign bus_off  = addr[3:0];
  assign bus_wr   = bus_hit && wr;
  // Only code 1 in the upper half queues a frame
  assign cmd_write = bus_wr && (bus_off == OFF_PROGRAM) && (data_in[31:16] == ADC_CMD_NEW_VALUE);

  // Configuration writes
  always_ff @(posedge clk) begin
    if (reset) begin
      divide       <= '0;
      overflow_bus <= '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        end_time[i]   <= '0;
        start_time[i] <= '0;
      end
    end else if (bus_wr) begin
      case (bus_off)
        OFF_OVERFLOW: overflow_bus[bus_chan] <= data_in[15:0];
        // DIVIDE is shared by all channels
        OFF_DIVIDE:   divide <= data_in[15:0];
        OFF_ENDTIME:  end_time[bus_chan] <= data_in;
        OFF_RECSTART: start_time[bus_chan] <= data_in;
        default: ;
      endcase
    end
  end

  // Pending command, a new write wins over the take pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_pending <= 1'b0;
      cmd_word    <= '0;
    end else if (cmd_write) begin
      cmd_pending <= 1'b1;
      cmd_word    <= data_in[15:0];
    end else if (cmd_taken) begin
      cmd_pending <= 1'b0;
    end
  end

  // Read data, zero after any cycle without a read hit
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (bus_hit && re) begin
      case (bus_off)
        OFF_SAMPLE:   data_out <= sample_bus[bus_chan];
        OFF_SEQUENCE: data_out <= seq_bus[bus_chan];
        OFF_ID:       data_out <= ID_VALUE;
        OFF_BUSY:     data_out <= {{(FRAME_BITS-1){1'b0}}, busy};
        OFF_LAST:     data_out <= last_cmd;
        default:      data_out <= '0;
      endcase
    end else begin
      data_out <= '0;
    end
  end

  // ----------------------------------------
  // Stream port
  // ----------------------------------------
  assign sel_hit   = (channel_select >= 8'(MIN_CHANNEL)) && (channel_select <= 8'(MAX_CHANNEL));
  assign sel_chan  = chan_t'(channel_select - 8'(MIN_CHANNEL));
  assign sel_start = start_time[sel_chan];
  assign sel_end   = end_time[sel_chan];
  // Open after start; end of 0 keeps it open
  assign window_open = (sel_start != '0) && (sel_start < current_time) &&
                       ((current_time < sel_end) || (sel_end == '0));

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
      sample_data  <= '0;
    end else begin
      sample_valid <= output_sample && sel_hit;
      if (output_sample && sel_hit) begin
        sample_data <= window_open ? {seq_bus[sel_chan], sample_bus[sel_chan]} : CLOSED_PATTERN;
      end else begin
        sample_data <= '0;
      end
    end
  end

  // Serial engine only takes a command that is actually queued
  assert property (@(posedge clk) disable iff (reset) cmd_taken |-> cmd_pending);

endmodule

/* design/adc_pkg.sv */
// Shared ADC controller types and constants; 8 channels and 16-bit frames are fixed throughout
package adc_pkg;

  // ----------------------------------------
  // Data types
  // ----------------------------------------
  // One ADC word or stored sample
  typedef logic [15:0] sample_t;
  // Per-channel sequence number
  typedef logic [15:0] seq_t;
  // Host timestamp, also used for window limits
  typedef logic [31:0] time_t;
  // Channel index 0 to 7
  typedef logic [2:0]  chan_t;
  // Register offset from addr bits 3:0
  typedef logic [3:0]  reg_off_t;

  // Serial engine states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PROGRAM,
    ST_CONVERT,
    ST_COPY
  } serial_state_t;

  // ----------------------------------------
  // Constants
  // ----------------------------------------
  localparam int NUM_CHANNELS = 8;
  // Bus channel codes that address this block
  localparam int MIN_CHANNEL  = 100;
  localparam int MAX_CHANNEL  = 107;
  localparam int FRAME_BITS   = 16;
  // Idle bit periods with cs high after a frame
  localparam int GAP_BITS     = 2;

  // Command code in PROGRAM bits 31:16
  localparam logic [15:0] ADC_CMD_NEW_VALUE = 16'd1;
  localparam sample_t     ID_VALUE          = 16'h0ADC;
  // Stream value while the window is closed
  localparam logic [31:0] CLOSED_PATTERN    = 32'hADADADAD;

  // Register offsets
  localparam reg_off_t OFF_OVERFLOW = 4'd1;
  localparam reg_off_t OFF_DIVIDE   = 4'd2;
  localparam reg_off_t OFF_ENDTIME  = 4'd3;
  localparam reg_off_t OFF_PROGRAM  = 4'd4;
  localparam reg_off_t OFF_SAMPLE   = 4'd7;
  localparam reg_off_t OFF_SEQUENCE = 4'd8;
  localparam reg_off_t OFF_ID       = 4'd9;
  localparam reg_off_t OFF_BUSY     = 4'd10;
  localparam reg_off_t OFF_LAST     = 4'd11;
  localparam reg_off_t OFF_RECSTART = 4'd12;

endpackage
